// ==== llc_cfg_pkg.sv ====
package llc_cfg_pkg;

  // descriptor ID width as seen on the request stream
  localparam int unsigned IdWidth = 4;

  // only the low ID bits pick an ordering counter, so IDs that share them
  // are kept in order against each other as well
  localparam int unsigned UseIdBits = 2;
  localparam int unsigned NoCounters = 2 ** UseIdBits;

  // per-ID outstanding count, all ones means full and stalls intake
  localparam int unsigned MissCntWidth = 2;

  // the write counter tracks every write in the miss path, whatever its ID
  localparam int unsigned MissCntMaxWWidth = 3;

  // miss FIFO sizing
  localparam int unsigned FifoDepth = 8;
  localparam int unsigned FifoPtrWidth = (FifoDepth > 1) ? $clog2(FifoDepth) : 1;

  // cycles a descriptor spends in refill inside the miss unit
  localparam int unsigned MissLatency = 4;

  // refill cycle counter holds values up to MissLatency - 1
  localparam int unsigned RefillCntWidth = (MissLatency > 1) ? $clog2(MissLatency) : 1;

  // address tag carried along with the descriptor, not interpreted here
  localparam int unsigned TagWidth = 8;

endpackage

// ==== llc_desc_pkg.sv ====
package llc_desc_pkg;
  import llc_cfg_pkg::*;

  // operation of a request descriptor
  typedef enum logic {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } desc_op_e;

  // request descriptor as it travels on the input, hit and miss streams
  // the hit bit is the result of the tag lookup done upstream
  typedef struct packed {
    logic [IdWidth-1:0]  id;
    desc_op_e            op;
    logic                hit;
    logic [TagWidth-1:0] tag;
  } desc_t;

  // one counter event, either entering or leaving the miss path
  typedef struct packed {
    // ID of the descriptor that moves the counter
    logic [IdWidth-1:0] id;
    // 1 for a write, which also moves the write counter
    logic               rw;
    // the event is only applied when this is set
    logic               valid;
  } cnt_t;

  // miss unit states
  typedef enum logic [1:0] {
    MS_IDLE   = 2'd0,
    MS_REFILL = 2'd1,
    MS_DONE   = 2'd2
  } miss_state_e;

endpackage

// ==== llc_up_down_counter.sv ====
`timescale 1ns/1ps

module llc_up_down_counter #(
  parameter int unsigned Width = 2
) (
  input  logic             clk_i,
  input  logic             reset_i,
  input  logic             en_i,
  input  logic             down_i,
  output logic [Width-1:0] q_o,
  output logic             full_o
);

  logic [Width-1:0] cnt_q;

  // full means all ones, the owner of the counter stalls on it so an
  // increment past this value should never be requested
  assign full_o = &cnt_q;
  assign q_o    = cnt_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      cnt_q <= '0;
    end else if (en_i) begin
      if (down_i) begin
        // never step below zero, a stray decrement leaves the value alone
        if (cnt_q != '0) begin
          cnt_q <= cnt_q - 1'b1;
        end
      end else begin
        // hold at all ones instead of wrapping back to zero
        if (!full_o) begin
          cnt_q <= cnt_q + 1'b1;
        end
      end
    end
  end

endmodule

// ==== llc_miss_counters.sv ====
`timescale 1ns/1ps

module llc_miss_counters
  import llc_cfg_pkg::*;
  import llc_desc_pkg::*;
(
  input  logic clk_i,
  input  logic reset_i,
  // descriptor enters the miss path
  input  cnt_t cnt_up_i,
  // descriptor leaves the miss path
  input  cnt_t cnt_down_i,
  // the offered descriptor has to follow earlier ones through the miss path
  output logic to_miss_o,
  // some counter is at its full value, intake has to wait
  output logic stall_o
);

  // one full flag per ID counter plus the write counter on the top bit
  logic [NoCounters:0]                      full;
  logic [NoCounters-1:0]                    en;
  logic [NoCounters-1:0]                    down;
  logic [NoCounters-1:0][MissCntWidth-1:0]  q_miss;
  logic [MissCntMaxWWidth-1:0]              q_write;
  logic [UseIdBits-1:0]                     up_sel;
  logic [UseIdBits-1:0]                     down_sel;
  logic                                     up_w_evt;
  logic                                     down_w_evt;
  logic                                     en_w;
  logic                                     down_w;

  // only the low ID bits select the counter
  assign up_sel   = cnt_up_i.id[UseIdBits-1:0];
  assign down_sel = cnt_down_i.id[UseIdBits-1:0];

  // per-ID enable and direction
  // an up and a down on the same counter in one cycle leave it unchanged
  always_comb begin : proc_id_ctrl
    for (int unsigned i = 0; i < NoCounters; i++) begin
      en[i]   = 1'b0;
      down[i] = 1'b0;
      if (cnt_up_i.valid && (up_sel == UseIdBits'(i))) begin
        en[i] = 1'b1;
      end
      if (cnt_down_i.valid && (down_sel == UseIdBits'(i))) begin
        // a pending up cancels out with this down
        en[i]   = ~en[i];
        down[i] = 1'b1;
      end
    end
  end

  // the write counter follows the same rule, only writes move it
  assign up_w_evt   = cnt_up_i.valid & cnt_up_i.rw;
  assign down_w_evt = cnt_down_i.valid & cnt_down_i.rw;
  assign en_w       = up_w_evt ^ down_w_evt;
  assign down_w     = down_w_evt;

  // the decision uses the ID and op of the offered descriptor even before
  // it is accepted, valid is not part of it
  // a write has to wait for every earlier write as well
  assign to_miss_o = (|q_miss[up_sel]) | (cnt_up_i.rw & (|q_write));

  assign stall_o = |full;

  for (genvar j = 0; j < NoCounters; j++) begin : gen_id_cnt
    llc_up_down_counter #(
      .Width   ( MissCntWidth )
    ) u_miss_cnt (
      .clk_i   ( clk_i     ),
      .reset_i ( reset_i   ),
      .en_i    ( en[j]     ),
      .down_i  ( down[j]   ),
      .q_o     ( q_miss[j] ),
      .full_o  ( full[j]   )
    );
  end

  llc_up_down_counter #(
    .Width   ( MissCntMaxWWidth )
  ) u_write_cnt (
    .clk_i   ( clk_i            ),
    .reset_i ( reset_i          ),
    .en_i    ( en_w             ),
    .down_i  ( down_w           ),
    .q_o     ( q_write          ),
    .full_o  ( full[NoCounters] )
  );

endmodule

// ==== llc_dispatch.sv ====
`timescale 1ns/1ps

module llc_dispatch
  import llc_desc_pkg::*;
(
  input  logic  clk_i,
  input  logic  reset_i,
  // request stream
  input  desc_t desc_i,
  input  logic  in_valid_i,
  output logic  in_ready_o,
  // ordering status from the counters
  input  logic  to_miss_i,
  input  logic  stall_i,
  output cnt_t  cnt_up_o,
  // miss FIFO write side, its data comes straight from desc_i
  output logic  push_o,
  input  logic  fifo_full_i,
  // hit stream
  output desc_t hit_o,
  output logic  hit_valid_o,
  input  logic  hit_ready_i
);

  logic  miss_path;
  logic  hit_room;
  logic  accept;
  logic  hit_valid_q;
  desc_t hit_q;

  // a descriptor goes to the miss path when the lookup missed or when an
  // earlier descriptor it must stay behind is still there
  assign miss_path = ~desc_i.hit | to_miss_i;

  // the hit register can take a new entry when empty or drained this cycle
  assign hit_room = ~hit_valid_q | hit_ready_i;

  // ready depends on where the offered descriptor is headed
  // a full counter blocks both paths
  assign in_ready_o = ~stall_i & (miss_path ? ~fifo_full_i : hit_room);
  assign accept     = in_valid_i & in_ready_o;

  assign push_o = accept & miss_path;

  // the counters see the offered ID and op all the time so that to_miss
  // can be evaluated, the event itself only counts on a miss-path accept
  assign cnt_up_o.id    = desc_i.id;
  assign cnt_up_o.rw    = (desc_i.op == OP_WRITE);
  assign cnt_up_o.valid = push_o;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      hit_valid_q <= 1'b0;
    end else if (accept && !miss_path) begin
      hit_valid_q <= 1'b1;
    end else if (hit_ready_i) begin
      hit_valid_q <= 1'b0;
    end
  end

  // payload register, only loaded on a hit-path accept
  always_ff @(posedge clk_i) begin
    if (accept && !miss_path) begin
      hit_q <= desc_i;
    end
  end

  assign hit_o       = hit_q;
  assign hit_valid_o = hit_valid_q;

endmodule

// ==== llc_miss_fifo.sv ====
`timescale 1ns/1ps

module llc_miss_fifo
  import llc_cfg_pkg::*;
  import llc_desc_pkg::*;
(
  input  logic  clk_i,
  input  logic  reset_i,
  input  logic  push_i,
  input  desc_t data_i,
  input  logic  pop_i,
  output desc_t data_o,
  output logic  full_o,
  output logic  empty_o
);

  desc_t                   mem_q [FifoDepth];
  logic [FifoPtrWidth-1:0] wr_ptr_q;
  logic [FifoPtrWidth-1:0] rd_ptr_q;
  // one bit wider than the pointers so that a full buffer can be told apart
  logic [FifoPtrWidth:0]   count_q;
  logic                    do_push;
  logic                    do_pop;

  assign full_o  = (count_q == (FifoPtrWidth + 1)'(FifoDepth));
  assign empty_o = (count_q == '0);

  // requests that cannot be served are dropped
  assign do_push = push_i & ~full_o;
  assign do_pop  = pop_i & ~empty_o;

  // head entry is visible all the time, the miss unit samples it on pop
  assign data_o = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        // wrap explicitly, the depth need not be a power of two
        if (wr_ptr_q == FifoPtrWidth'(FifoDepth - 1)) begin
          wr_ptr_q <= '0;
        end else begin
          wr_ptr_q <= wr_ptr_q + 1'b1;
        end
      end
      if (do_pop) begin
        if (rd_ptr_q == FifoPtrWidth'(FifoDepth - 1)) begin
          rd_ptr_q <= '0;
        end else begin
          rd_ptr_q <= rd_ptr_q + 1'b1;
        end
      end
      // simultaneous push and pop keep the fill level
      if (do_push && !do_pop) begin
        count_q <= count_q + 1'b1;
      end else if (do_pop && !do_push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  // storage has no reset, the fill count says which entries are valid
  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

endmodule

// ==== llc_miss_unit.sv ====
`timescale 1ns/1ps

module llc_miss_unit
  import llc_cfg_pkg::*;
  import llc_desc_pkg::*;
(
  input  logic  clk_i,
  input  logic  reset_i,
  // miss FIFO read side
  input  desc_t fifo_data_i,
  input  logic  fifo_empty_i,
  output logic  pop_o,
  // miss stream
  output desc_t miss_o,
  output logic  miss_valid_o,
  input  logic  miss_ready_i,
  // retire event towards the counters
  output cnt_t  cnt_down_o
);

  miss_state_e               state_q;
  miss_state_e               state_d;
  logic [RefillCntWidth-1:0] refill_q;
  desc_t                     desc_q;
  logic                      out_xfer;

  // one descriptor at a time, only an idle unit takes the next head
  assign pop_o = (state_q == MS_IDLE) & ~fifo_empty_i;

  assign miss_valid_o = (state_q == MS_DONE);
  assign miss_o       = desc_q;
  assign out_xfer     = miss_valid_o & miss_ready_i;

  // the descriptor leaves the miss path on its output transfer
  assign cnt_down_o.id    = desc_q.id;
  assign cnt_down_o.rw    = (desc_q.op == OP_WRITE);
  assign cnt_down_o.valid = out_xfer;

  always_comb begin : proc_next_state
    state_d = state_q;
    unique case (state_q)
      MS_IDLE: begin
        if (pop_o) begin
          state_d = MS_REFILL;
        end
      end
      MS_REFILL: begin
        // refill_q counts the remaining refill cycles down to zero
        if (refill_q == '0) begin
          state_d = MS_DONE;
        end
      end
      MS_DONE: begin
        // stay here as long as the miss output is back-pressured
        if (out_xfer) begin
          state_d = MS_IDLE;
        end
      end
      default: state_d = MS_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q  <= MS_IDLE;
      refill_q <= '0;
    end else begin
      state_q <= state_d;
      if (pop_o) begin
        // MissLatency cycles in MS_REFILL, counting the last one at zero
        refill_q <= RefillCntWidth'(MissLatency - 1);
      end else if ((state_q == MS_REFILL) && (refill_q != '0)) begin
        refill_q <= refill_q - 1'b1;
      end
    end
  end

  // the head is captured on the popping edge and held until retired
  always_ff @(posedge clk_i) begin
    if (pop_o) begin
      desc_q <= fifo_data_i;
    end
  end

endmodule

// ==== llc_miss_track_top.sv ====
`timescale 1ns/1ps

module llc_miss_track_top
  import llc_desc_pkg::*;
(
  input  logic  clk_i,
  input  logic  reset_i,
  // request stream
  input  desc_t desc_i,
  input  logic  in_valid_i,
  output logic  in_ready_o,
  // hit stream
  output desc_t hit_o,
  output logic  hit_valid_o,
  input  logic  hit_ready_i,
  // miss stream
  output desc_t miss_o,
  output logic  miss_valid_o,
  input  logic  miss_ready_i
);

  cnt_t  cnt_up;
  cnt_t  cnt_down;
  logic  to_miss;
  logic  stall;
  logic  push;
  logic  pop;
  logic  fifo_full;
  logic  fifo_empty;
  desc_t fifo_data;

  llc_dispatch u_dispatch (
    .clk_i       ( clk_i       ),
    .reset_i     ( reset_i     ),
    .desc_i      ( desc_i      ),
    .in_valid_i  ( in_valid_i  ),
    .in_ready_o  ( in_ready_o  ),
    .to_miss_i   ( to_miss     ),
    .stall_i     ( stall       ),
    .cnt_up_o    ( cnt_up      ),
    .push_o      ( push        ),
    .fifo_full_i ( fifo_full   ),
    .hit_o       ( hit_o       ),
    .hit_valid_o ( hit_valid_o ),
    .hit_ready_i ( hit_ready_i )
  );

  // counters see entries from the dispatcher and retirements from the miss unit
  llc_miss_counters u_miss_counters (
    .clk_i      ( clk_i    ),
    .reset_i    ( reset_i  ),
    .cnt_up_i   ( cnt_up   ),
    .cnt_down_i ( cnt_down ),
    .to_miss_o  ( to_miss  ),
    .stall_o    ( stall    )
  );

  // the FIFO is written with the offered descriptor itself
  llc_miss_fifo u_miss_fifo (
    .clk_i   ( clk_i      ),
    .reset_i ( reset_i    ),
    .push_i  ( push       ),
    .data_i  ( desc_i     ),
    .pop_i   ( pop        ),
    .data_o  ( fifo_data  ),
    .full_o  ( fifo_full  ),
    .empty_o ( fifo_empty )
  );

  llc_miss_unit u_miss_unit (
    .clk_i        ( clk_i        ),
    .reset_i      ( reset_i      ),
    .fifo_data_i  ( fifo_data    ),
    .fifo_empty_i ( fifo_empty   ),
    .pop_o        ( pop          ),
    .miss_o       ( miss_o       ),
    .miss_valid_o ( miss_valid_o ),
    .miss_ready_i ( miss_ready_i ),
    .cnt_down_o   ( cnt_down     )
  );

endmodule

// ==== llc_miss_track_asserts.sv ====
`timescale 1ns/1ps

module llc_miss_track_asserts
  import llc_cfg_pkg::*;
  import llc_desc_pkg::*;
(
  input logic                                  clk_i,
  input logic                                  reset_i,
  input logic                                  in_ready_i,
  input desc_t                                 hit_i,
  input logic                                  hit_valid_i,
  input logic                                  hit_ready_i,
  input desc_t                                 miss_i,
  input logic                                  miss_valid_i,
  input logic                                  miss_ready_i,
  input logic                                  push_i,
  input logic                                  pop_i,
  input logic [NoCounters-1:0][MissCntWidth-1:0] miss_cnt_i,
  input logic [MissCntMaxWWidth-1:0]           write_cnt_i
);

  // number of failed assertions, read by the testbench at the end
  int unsigned fail_cnt = 0;

  // miss FIFO occupancy rebuilt from the push and pop strobes
  int   fill_q;
  // some ordering counter sits at its all ones value
  logic any_full;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      fill_q <= 0;
    end else begin
      fill_q <= fill_q + int'(push_i) - int'(pop_i);
    end
  end

  always_comb begin
    any_full = (write_cnt_i == '1);
    for (int i = 0; i < NoCounters; i++) begin
      if (miss_cnt_i[i] == '1) begin
        any_full = 1'b1;
      end
    end
  end

  // a waiting output keeps its valid and its data
  hit_stable: assert property (@(posedge clk_i) disable iff (reset_i)
    hit_valid_i && !hit_ready_i |=> hit_valid_i && $stable(hit_i))
    else begin fail_cnt++; $error("hit output changed before its transfer"); end

  miss_stable: assert property (@(posedge clk_i) disable iff (reset_i)
    miss_valid_i && !miss_ready_i |=> miss_valid_i && $stable(miss_i))
    else begin fail_cnt++; $error("miss output changed before its transfer"); end

  // reset leaves both outputs idle
  reset_idle: assert property (@(posedge clk_i)
    reset_i |=> !hit_valid_i && !miss_valid_i)
    else begin fail_cnt++; $error("output valid right after reset"); end

  // a full counter closes intake
  full_stall: assert property (@(posedge clk_i) disable iff (reset_i)
    any_full |-> !in_ready_i)
    else begin fail_cnt++; $error("intake open while a counter is full"); end

  push_room: assert property (@(posedge clk_i) disable iff (reset_i)
    push_i |-> (fill_q < int'(FifoDepth)))
    else begin fail_cnt++; $error("push into a full miss FIFO"); end

  pop_data: assert property (@(posedge clk_i) disable iff (reset_i)
    pop_i |-> (fill_q > 0))
    else begin fail_cnt++; $error("pop from an empty miss FIFO"); end

  // the miss output only rises once the whole refill after a pop has passed
  refill_wait: assert property (@(posedge clk_i) disable iff (reset_i)
    $rose(miss_valid_i) |-> $past(pop_i, MissLatency + 1))
    else begin fail_cnt++; $error("miss output valid before the refill time"); end

  refill_end: assert property (@(posedge clk_i) disable iff (reset_i)
    pop_i |-> ##(MissLatency + 1) miss_valid_i)
    else begin fail_cnt++; $error("miss output not valid after the refill time"); end

endmodule

bind llc_miss_track_top llc_miss_track_asserts u_asserts (
  .clk_i        ( clk_i                   ),
  .reset_i      ( reset_i                 ),
  .in_ready_i   ( in_ready_o              ),
  .hit_i        ( hit_o                   ),
  .hit_valid_i  ( hit_valid_o             ),
  .hit_ready_i  ( hit_ready_i             ),
  .miss_i       ( miss_o                  ),
  .miss_valid_i ( miss_valid_o            ),
  .miss_ready_i ( miss_ready_i            ),
  .push_i       ( push                    ),
  .pop_i        ( pop                     ),
  .miss_cnt_i   ( u_miss_counters.q_miss  ),
  .write_cnt_i  ( u_miss_counters.q_write )
);

// ==== tb_llc_miss_track.sv ====
`timescale 1ns/1ps

module tb_llc_miss_track
  import llc_cfg_pkg::*;
  import llc_desc_pkg::*;
();

  localparam int unsigned NumTests   = 6;
  localparam int unsigned TestCycles = 300;
  localparam int unsigned NumRandom  = 60;

  logic  clk_i;
  logic  reset_i;
  desc_t desc_i;
  logic  in_valid_i;
  logic  in_ready_o;
  desc_t hit_o;
  logic  hit_valid_o;
  logic  hit_ready_i;
  desc_t miss_o;
  logic  miss_valid_o;
  logic  miss_ready_i;

  // reference model state, counts of descriptors still in the miss path
  int    ref_cnt [NoCounters];
  int    ref_wcnt;
  desc_t exp_hit[$];
  desc_t exp_miss[$];
  logic  hit_due;
  logic  to_miss_ref;
  desc_t exp_d;

  int          seed;
  int unsigned err_cnt;
  int unsigned tests_ok;
  int unsigned tests_bad;
  int unsigned err_at_start;
  int unsigned n;
  logic        rand_done;

  llc_miss_track_top u_dut (
    .clk_i        ( clk_i        ),
    .reset_i      ( reset_i      ),
    .desc_i       ( desc_i       ),
    .in_valid_i   ( in_valid_i   ),
    .in_ready_o   ( in_ready_o   ),
    .hit_o        ( hit_o        ),
    .hit_valid_o  ( hit_valid_o  ),
    .hit_ready_i  ( hit_ready_i  ),
    .miss_o       ( miss_o       ),
    .miss_valid_o ( miss_valid_o ),
    .miss_ready_i ( miss_ready_i )
  );

  always #4 clk_i = ~clk_i;

  task automatic report_mismatch(input string msg);
    $display("mismatch at %0t: %s", $time, msg);
    err_cnt++;
  endtask

  task automatic report_error(input string msg);
    $display("error at %0t: %s", $time, msg);
    err_cnt++;
  endtask

  // the bound checker counts its own assertion failures
  function automatic int unsigned total_errors();
    return err_cnt + u_dut.u_asserts.fail_cnt;
  endfunction

  function automatic desc_t make_desc(input int id, input desc_op_e op, input logic hit);
    desc_t d;
    d.id  = IdWidth'(id);
    d.op  = op;
    d.hit = hit;
    d.tag = TagWidth'($random(seed));
    return d;
  endfunction

  // offer one descriptor from a falling edge and hold it until accepted
  task automatic send(input desc_t d);
    desc_i     = d;
    in_valid_i = 1'b1;
    @(posedge clk_i);
    while (!in_ready_o) begin
      @(posedge clk_i);
    end
    @(negedge clk_i);
    in_valid_i = 1'b0;
  endtask

  // wait until the model expects nothing more on either output
  task automatic drain();
    while (exp_hit.size() != 0 || exp_miss.size() != 0) begin
      @(negedge clk_i);
    end
    @(negedge clk_i);
  endtask

  task automatic end_test(input int num, input string name);
    if (total_errors() == err_at_start) begin
      tests_ok++;
      $display("test %0d %s: ok", num, name);
    end else begin
      tests_bad++;
      $display("test %0d %s: failed", num, name);
    end
    err_at_start = total_errors();
  endtask

  // reference model, sampled on the rising edge before any register updates
  always @(posedge clk_i) begin
    if (!reset_i) begin
      // a hit-path descriptor must show up right after its accepting edge
      if (hit_due) begin
        assert (hit_valid_o) else report_mismatch("hit output not valid 1 cycle after accept");
      end
      hit_due = 1'b0;
      // routing uses the counts as they stand before this edge
      to_miss_ref = (ref_cnt[desc_i.id[UseIdBits-1:0]] != 0) ||
                    ((desc_i.op == OP_WRITE) && (ref_wcnt != 0));
      if (hit_valid_o && hit_ready_i) begin
        if (exp_hit.size() == 0) begin
          report_error("descriptor on the hit output that the model did not expect");
        end else begin
          exp_d = exp_hit.pop_front();
          assert (hit_o == exp_d)
            else report_mismatch($sformatf("hit got %h expected %h", hit_o, exp_d));
        end
      end
      if (miss_valid_o && miss_ready_i) begin
        if (exp_miss.size() == 0) begin
          report_error("descriptor on the miss output that the model did not expect");
        end else begin
          exp_d = exp_miss.pop_front();
          assert (miss_o == exp_d)
            else report_mismatch($sformatf("miss got %h expected %h", miss_o, exp_d));
          // the expected one retires, so the model stays sane after a mismatch
          ref_cnt[exp_d.id[UseIdBits-1:0]]--;
          if (exp_d.op == OP_WRITE) begin
            ref_wcnt--;
          end
        end
      end
      if (in_valid_i && in_ready_o) begin
        if (!desc_i.hit || to_miss_ref) begin
          exp_miss.push_back(desc_i);
          ref_cnt[desc_i.id[UseIdBits-1:0]]++;
          if (desc_i.op == OP_WRITE) begin
            ref_wcnt++;
          end
        end else begin
          exp_hit.push_back(desc_i);
          hit_due = 1'b1;
        end
      end
    end
  end

  // watchdog sized from the number of tests and the cycles each may take
  initial begin
    #(NumTests * TestCycles * 8);
    $display("timeout: the tests did not complete in time");
    $display("Simulation finished: FAIL");
    $finish;
  end

  initial begin
    clk_i        = 1'b0;
    reset_i      = 1'b1;
    desc_i       = '0;
    in_valid_i   = 1'b0;
    hit_ready_i  = 1'b1;
    miss_ready_i = 1'b1;
    seed         = 6;
    err_cnt      = 0;
    tests_ok     = 0;
    tests_bad    = 0;
    err_at_start = 0;
    hit_due      = 1'b0;
    rand_done    = 1'b0;
    ref_wcnt     = 0;
    for (int i = 0; i < NoCounters; i++) begin
      ref_cnt[i] = 0;
    end
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    reset_i = 1'b0;

    // outputs idle and intake open right after reset
    assert (!hit_valid_o && !miss_valid_o) else report_mismatch("outputs valid after reset");
    assert (in_ready_o) else report_mismatch("in_ready_o low after reset");
    end_test(1, "reset state");

    // plain hits leave in order with nothing in the miss path
    for (int i = 0; i < 4; i++) begin
      send(make_desc(i, OP_READ, 1'b1));
    end
    drain();
    end_test(2, "hits in order");

    // hold the miss so that a later hit to the same ID has to follow it
    miss_ready_i = 1'b0;
    send(make_desc(1, OP_READ, 1'b0));
    n = 0;
    while (!miss_valid_o) begin
      @(negedge clk_i);
      n++;
    end
    assert (n == 1 + MissLatency)
      else report_mismatch($sformatf("miss latency %0d expected %0d", n, 1 + MissLatency));
    send(make_desc(5, OP_READ, 1'b1));
    miss_ready_i = 1'b1;
    drain();
    end_test(3, "miss latency and same-ID ordering");

    // an outstanding write pulls every write behind it but no other read
    miss_ready_i = 1'b0;
    send(make_desc(2, OP_WRITE, 1'b0));
    send(make_desc(3, OP_WRITE, 1'b1));
    send(make_desc(0, OP_READ, 1'b1));
    assert (hit_valid_o) else report_mismatch("read of another ID did not go to the hit output");
    miss_ready_i = 1'b1;
    drain();
    end_test(4, "write ordering");

    // three misses to one ID fill its counter and stall all intake
    miss_ready_i = 1'b0;
    for (int i = 0; i < 3; i++) begin
      send(make_desc(1, OP_READ, 1'b0));
    end
    for (int i = 0; i < NoCounters; i++) begin
      desc_i = make_desc(i, OP_READ, 1'b1);
      @(posedge clk_i);
      assert (!in_ready_o) else report_mismatch($sformatf("in_ready_o high for ID %0d", i));
      @(negedge clk_i);
    end
    miss_ready_i = 1'b1;
    @(posedge clk_i);
    while (!miss_valid_o) begin
      @(posedge clk_i);
    end
    @(negedge clk_i);
    assert (in_ready_o) else report_mismatch("in_ready_o still low after a miss retired");
    drain();
    end_test(5, "counter full stall");

    // random traffic under random back-pressure on both outputs
    fork
      begin
        for (int i = 0; i < NumRandom; i++) begin
          send(make_desc($random(seed), desc_op_e'($random(seed)), 1'($random(seed))));
          if (($random(seed) & 3) == 0) begin
            @(negedge clk_i);
          end
        end
        rand_done = 1'b1;
      end
      begin
        while (!rand_done) begin
          @(negedge clk_i);
          hit_ready_i  = (($random(seed) & 3) != 0);
          miss_ready_i = (($random(seed) & 3) != 0);
        end
      end
    join
    hit_ready_i  = 1'b1;
    miss_ready_i = 1'b1;
    drain();
    end_test(6, "random traffic");

    $display("tests passed: %0d, tests failed: %0d", tests_ok, tests_bad);
    if (tests_bad == 0 && total_errors() == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

// ==== llc_miss_track.f ====
llc_cfg_pkg.sv
llc_desc_pkg.sv
llc_up_down_counter.sv
llc_miss_counters.sv
llc_dispatch.sv
llc_miss_fifo.sv
llc_miss_unit.sv
llc_miss_track_top.sv
llc_miss_track_asserts.sv
tb_llc_miss_track.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_llc_miss_track
RTL_TOP   ?= llc_miss_track_top
FLIST     ?= llc_miss_track.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
RUNFLAGS  ?= +verilator+error+limit+1000
PASS_MSG  ?= Simulation finished: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(RUNFLAGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^$(PASS_MSG)$$"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR)
